// ==== busArbiter.sv ====
/*
 * round-robin arbiter between the two DMA channels,
 * relays the four-phase handshake to the external memory bus
 */
`timescale 1ns/1ps
`default_nettype none

module busArbiter (
	input wire in_clk,
	input wire reset,
	input wire req0,
	input wire req1,
	input wire ioPkg::memAddr_t addr0,
	input wire ioPkg::memAddr_t addr1,
	input wire ioPkg::ioWord_t data0,
	input wire ioPkg::ioWord_t data1,
	input wire memAck,
	output logic ack0,
	output logic ack1,
	output logic memReq,
	output ioPkg::memAddr_t memAddr,
	output ioPkg::ioWord_t memData
);
	import ioPkg::*;

	arbState_e state;
	// channel granted now, or served last while idle
	logic grantSel;
	logic pick;
	logic grantReq;
	logic anyReq;

	assign anyReq = req0 || req1;

	// a tie goes to the channel not served last
	assign pick = (req0 && req1) ? !grantSel : req1;

	// request of the channel holding the grant
	assign grantReq = grantSel ? req1 : req0;

	// memory ack goes straight back to the owner
	assign ack0 = memAck && !grantSel;
	assign ack1 = memAck && grantSel;

	always_ff @(posedge in_clk) begin
		if (reset) begin
			state <= Idle;
			// floppy counts as served last
			grantSel <= 1'b0;
			memReq <= 1'b0;
		end else begin
			case (state)
				Idle: begin
					if (anyReq) begin
						grantSel <= pick;
						state <= Busy;
					end
				end
				Busy: begin
					if (memReq && memAck) begin
						memReq <= 1'b0;
						state <= Drop;
					end else if (!memReq && !memAck) begin
						// one cycle after the grant
						memReq <= 1'b1;
					end
				end
				Drop: begin
					// both sides back to zero closes the transfer
					if (!memAck && !grantReq)
						state <= Idle;
				end
				default: begin
					state <= Idle;
				end
			endcase
		end
	end

	// winner's word held on the bus for the whole transfer
	always_ff @(posedge in_clk) begin
		if (state == Idle && anyReq) begin
			memAddr <= pick ? addr1 : addr0;
			memData <= pick ? data1 : data0;
		end
	end

endmodule

`default_nettype wire

// ==== dmaChannel.sv ====
/*
 * DMA engine for one channel, packs FIFO bytes big-endian into words
 * and writes them to consecutive addresses over a four-phase handshake
 */
`timescale 1ns/1ps
`default_nettype none
`include "ioBridge_cfg.svh"

module dmaChannel #(
	parameter ioPkg::memAddr_t BASE_ADDR = `IO_FLOPPY_BASE
) (
	input wire in_clk,
	input wire reset,
	input wire ioPkg::ioByte_t fifoData,
	input wire dataAvailable,
	input wire chanAck,
	output logic readEn,
	output logic chanReq,
	output ioPkg::memAddr_t chanAddr,
	output ioPkg::ioWord_t chanData
);
	import ioPkg::*;

	dmaState_e state;
	// first byte of the pair, waits for its partner
	ioByte_t highByte;
	logic haveHigh;

	// pop one byte per cycle, only while collecting
	assign readEn = (state == Collect) && dataAvailable;

	always_ff @(posedge in_clk) begin
		if (reset) begin
			state <= Collect;
			haveHigh <= 1'b0;
			chanReq <= 1'b0;
			chanAddr <= BASE_ADDR;
		end else begin
			case (state)
				Collect: begin
					if (readEn) begin
						if (!haveHigh) begin
							haveHigh <= 1'b1;
						end else begin
							// word complete
							haveHigh <= 1'b0;
							state <= Request;
						end
					end
				end
				Request: begin
					if (chanAck) begin
						// ack seen, second phase
						chanReq <= 1'b0;
						state <= Release;
					end else if (!chanReq) begin
						// previous ack is low, safe to raise
						chanReq <= 1'b1;
					end
				end
				Release: begin
					// wait for ack to fall, then next word slot
					if (!chanAck) begin
						chanAddr <= chanAddr + 1'b1;
						state <= Collect;
					end
				end
				default: begin
					state <= Collect;
				end
			endcase
		end
	end

	// word register, stable from Request until the next pair
	always_ff @(posedge in_clk) begin
		if (readEn && !haveHigh)
			highByte <= fifoData;
		if (readEn && haveHigh)
			chanData <= {highByte, fifoData};
	end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+.
ioPkg.sv
ioFifo.sv
hostIf.sv
dmaChannel.sv
busArbiter.sv
ioBridge.sv
ioBridge_checker.sv
ioBridgeTb.sv

// ==== hostIf.sv ====
/*
 * host side routing, steers strobe and enable to the selected FIFO
 * and returns that FIFO's status
 */
`timescale 1ns/1ps
`default_nettype none

module hostIf (
	input wire in_clk,
	input wire reset,
	input wire hostChannel,
	input wire hostStrobe,
	input wire hostEnable,
	input wire ioPkg::fifoLevel_t space0,
	input wire ioPkg::fifoLevel_t space1,
	input wire full0,
	input wire full1,
	input wire empty0,
	input wire empty1,
	output logic wrStrobe0,
	output logic wrStrobe1,
	output logic wrEnable0,
	output logic wrEnable1,
	output ioPkg::fifoLevel_t hostSpace,
	output logic hostFull,
	output logic hostEmpty
);

	// 0 floppy, 1 ACSI
	logic chanSel;

	always_ff @(posedge in_clk) begin
		if (reset)
			chanSel <= 1'b0;
		else
			chanSel <= hostChannel;
	end

	// unselected FIFO sees both write paths low
	assign wrStrobe0 = hostStrobe && !chanSel;
	assign wrStrobe1 = hostStrobe && chanSel;
	assign wrEnable0 = hostEnable && !chanSel;
	assign wrEnable1 = hostEnable && chanSel;

	// status back from the selected channel
	assign hostSpace = chanSel ? space1 : space0;
	assign hostFull = chanSel ? full1 : full0;
	assign hostEmpty = chanSel ? empty1 : empty0;

endmodule

`default_nettype wire

// ==== ioBridge.sv ====
/*
 * I/O bridge top, host interface, floppy and ACSI FIFOs,
 * their DMA engines and the shared memory bus arbiter
 */
`timescale 1ns/1ps
`default_nettype none
`include "ioBridge_cfg.svh"

module ioBridge (
	input wire in_clk,
	input wire reset,
	input wire hostChannel,
	input wire ioPkg::ioByte_t hostData,
	input wire hostStrobe,
	input wire hostEnable,
	input wire memAck,
	output ioPkg::fifoLevel_t hostSpace,
	output logic hostFull,
	output logic hostEmpty,
	output logic memReq,
	output ioPkg::memAddr_t memAddr,
	output ioPkg::ioWord_t memData
);
	import ioPkg::*;

	// host interface to FIFOs
	logic wrStrobe0, wrStrobe1;
	logic wrEnable0, wrEnable1;
	fifoLevel_t space0, space1;
	logic full0, full1;
	logic empty0, empty1;

	// FIFOs to DMA engines
	ioByte_t fifoData0, fifoData1;
	logic avail0, avail1;
	logic readEn0, readEn1;

	// DMA engines to arbiter
	logic req0, req1;
	logic ack0, ack1;
	memAddr_t addr0, addr1;
	ioWord_t data0, data1;

	hostIf hostIf (.in_clk, .reset, .hostChannel, .hostStrobe, .hostEnable,
		.space0, .space1, .full0, .full1, .empty0, .empty1,
		.wrStrobe0, .wrStrobe1, .wrEnable0, .wrEnable1,
		.hostSpace, .hostFull, .hostEmpty);

	// host byte goes to both, only the selected one writes it
	ioFifo #(.FIFO_ADDR_BITS(`IO_FIFO_ADDR_BITS)) floppyFifo (.in_clk, .reset,
		.wrData(hostData), .wrStrobe(wrStrobe0), .wrEnable(wrEnable0), .readEn(readEn0),
		.rdData(fifoData0), .space(space0), .empty(empty0), .full(full0),
		.dataAvailable(avail0));

	ioFifo #(.FIFO_ADDR_BITS(`IO_FIFO_ADDR_BITS)) acsiFifo (.in_clk, .reset,
		.wrData(hostData), .wrStrobe(wrStrobe1), .wrEnable(wrEnable1), .readEn(readEn1),
		.rdData(fifoData1), .space(space1), .empty(empty1), .full(full1),
		.dataAvailable(avail1));

	dmaChannel #(.BASE_ADDR(`IO_FLOPPY_BASE)) floppyDma (.in_clk, .reset,
		.fifoData(fifoData0), .dataAvailable(avail0), .chanAck(ack0), .readEn(readEn0),
		.chanReq(req0), .chanAddr(addr0), .chanData(data0));

	dmaChannel #(.BASE_ADDR(`IO_ACSI_BASE)) acsiDma (.in_clk, .reset,
		.fifoData(fifoData1), .dataAvailable(avail1), .chanAck(ack1), .readEn(readEn1),
		.chanReq(req1), .chanAddr(addr1), .chanData(data1));

	// channel 0 floppy, channel 1 ACSI
	busArbiter busArbiter (.in_clk, .reset, .req0, .req1, .addr0, .addr1,
		.data0, .data1, .memAck, .ack0, .ack1, .memReq, .memAddr, .memData);

endmodule

`default_nettype wire

// ==== ioBridgeTb.sv ====
/*
 * directed testbench for the I/O bridge, clock and reset, memory model
 * acking after an LFSR drawn delay, one task per test and a check task
 */
`timescale 1ns/1ps
`default_nettype none
`include "ioBridge_cfg.svh"

module ioBridgeTb;
	import ioPkg::*;

	localparam int DRIVE_DELAY = 5;
	localparam int WAIT_LIMIT = 400;

	logic in_clk;
	logic reset;
	logic hostChannel;
	ioByte_t hostData;
	logic hostStrobe;
	logic hostEnable;
	logic memAck;
	fifoLevel_t hostSpace;
	logic hostFull;
	logic hostEmpty;
	logic memReq;
	memAddr_t memAddr;
	ioWord_t memData;

	// memory model state, hold keeps memAck off
	logic ackHold;
	logic [31:0] lfsrState = 32'h05ca14d7;
	memAddr_t wrAddrQ[$];
	ioWord_t wrDataQ[$];

	// next word address each channel should write
	memAddr_t floppyNext;
	memAddr_t acsiNext;

	ioBridge i_dut (.in_clk, .reset, .hostChannel, .hostData, .hostStrobe, .hostEnable,
		.memAck, .hostSpace, .hostFull, .hostEmpty, .memReq, .memAddr, .memData);

	initial begin
		in_clk = 1'b0;
		forever #50 in_clk = ~in_clk;
	end

	// Galois form, taps x^32 x^22 x^2 x^1
	function automatic logic [31:0] lfsrStep(input logic [31:0] state);
		if (state[0])
			return (state >> 1) ^ 32'h80200003;
		return state >> 1;
	endfunction

	// two bits, one step each, give 0 to 3 wait cycles
	function automatic int drawDelay();
		int cycles;
		int i;
		cycles = 0;
		for (i = 0; i < 2; i++) begin
			lfsrState = lfsrStep(lfsrState);
			cycles = cycles * 2 + (lfsrState[0] ? 1 : 0);
		end
		return cycles;
	endfunction

	// memory answers a little ahead of host stimulus
	initial begin : memoryModel
		int delayLeft;
		memAck = 1'b0;
		delayLeft = drawDelay();
		forever begin
			@(posedge in_clk);
			#(DRIVE_DELAY - 1);
			if (memAck) begin
				// ack follows req back down
				if (!memReq) begin
					memAck = 1'b0;
					delayLeft = drawDelay();
				end
			end else if (memReq && !ackHold) begin
				if (delayLeft == 0) begin
					wrAddrQ.push_back(memAddr);
					wrDataQ.push_back(memData);
					memAck = 1'b1;
				end else begin
					delayLeft--;
				end
			end
		end
	end

	task automatic stopRun();
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic checkValue(input string testName, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("[FAIL] %s expected %0h actual %0h", testName, expected, actual);
			stopRun();
		end
	endtask

	task automatic nextCycle();
		@(posedge in_clk);
		#DRIVE_DELAY;
	endtask

	task automatic idleCycles(input int count);
		repeat (count) nextCycle();
	endtask

	// channel select is registered in the DUT
	task automatic selectChannel(input logic chan);
		hostChannel = chan;
		nextCycle();
	endtask

	// stored at the next edge
	task automatic sendEnable(input ioByte_t value);
		hostData = value;
		hostEnable = 1'b1;
		nextCycle();
		hostEnable = 1'b0;
	endtask

	// stored 3 edges after the strobe rises, data held past that
	task automatic sendStrobe(input ioByte_t value);
		hostData = value;
		hostStrobe = 1'b1;
		idleCycles(3);
		hostStrobe = 1'b0;
		idleCycles(3);
	endtask

	task automatic waitWrites(input string testName, input int count);
		int waited;
		waited = 0;
		while (wrAddrQ.size() < count) begin
			if (waited == WAIT_LIMIT) begin
				$display("%s timed out waiting for %0d memory writes, only %0d arrived",
					testName, count, wrAddrQ.size());
				stopRun();
			end
			nextCycle();
			waited++;
		end
	endtask

	// oldest write seen by the memory
	task automatic checkWrite(input string testName, input memAddr_t addr, input ioWord_t data);
		memAddr_t gotAddr;
		ioWord_t gotData;
		gotAddr = wrAddrQ.pop_front();
		gotData = wrDataQ.pop_front();
		checkValue({testName, " address"}, 32'(addr), 32'(gotAddr));
		checkValue({testName, " data"}, 32'(data), 32'(gotData));
	endtask

	task automatic resetState();
		int chan;
		checkValue("reset memReq", 32'd0, 32'(memReq));
		for (chan = 0; chan < 2; chan++) begin
			selectChannel(chan[0]);
			checkValue("reset hostSpace", 32'd15, 32'(hostSpace));
			checkValue("reset hostEmpty", 32'd1, 32'(hostEmpty));
			checkValue("reset hostFull", 32'd0, 32'(hostFull));
		end
	endtask

	task automatic floppyStrobe();
		ioByte_t bytes[6];
		int i;
		selectChannel(1'b0);
		for (i = 0; i < 6; i++) begin
			bytes[i] = ioByte_t'(160 + i * 7);
			sendStrobe(bytes[i]);
		end
		waitWrites("floppy strobe", 3);
		for (i = 0; i < 3; i++) begin
			checkWrite("floppy strobe", floppyNext, {bytes[2 * i], bytes[2 * i + 1]});
			floppyNext = floppyNext + 16'd1;
		end
	endtask

	task automatic acsiEnable();
		ioByte_t bytes[8];
		int i;
		selectChannel(1'b1);
		for (i = 0; i < 8; i++) begin
			bytes[i] = ioByte_t'(17 + i * 29);
			sendEnable(bytes[i]);
		end
		waitWrites("acsi enable", 4);
		for (i = 0; i < 4; i++) begin
			checkWrite("acsi enable", acsiNext, {bytes[2 * i], bytes[2 * i + 1]});
			acsiNext = acsiNext + 16'd1;
		end
	endtask

	// ACSI queued first, so it owns the first grant and the rest alternate
	task automatic bothChannels();
		ioByte_t acsiBytes[6];
		ioByte_t floppyBytes[6];
		int i;
		ackHold = 1'b1;
		selectChannel(1'b1);
		for (i = 0; i < 6; i++) begin
			acsiBytes[i] = ioByte_t'(192 + i);
			sendEnable(acsiBytes[i]);
		end
		selectChannel(1'b0);
		for (i = 0; i < 6; i++) begin
			floppyBytes[i] = ioByte_t'(48 + i);
			sendEnable(floppyBytes[i]);
		end
		idleCycles(4);
		ackHold = 1'b0;
		waitWrites("both channels", 6);
		for (i = 0; i < 3; i++) begin
			checkWrite("both channels acsi", acsiNext, {acsiBytes[2 * i], acsiBytes[2 * i + 1]});
			acsiNext = acsiNext + 16'd1;
			checkWrite("both channels floppy", floppyNext,
				{floppyBytes[2 * i], floppyBytes[2 * i + 1]});
			floppyNext = floppyNext + 16'd1;
		end
	endtask

	task automatic backPressure();
		ioByte_t bytes[18];
		int n;
		ackHold = 1'b1;
		selectChannel(1'b0);
		for (n = 1; n <= 18; n++) begin
			bytes[n - 1] = ioByte_t'(64 + n * 3);
			sendEnable(bytes[n - 1]);
			idleCycles(2);
			// first pair already sits in the stalled DMA word
			if (n >= 2 && n <= 17)
				checkValue("backpressure hostSpace", 15 - (n - 2), 32'(hostSpace));
			if (n >= 17)
				checkValue("backpressure hostFull", 32'd1, 32'(hostFull));
		end
		checkValue("backpressure dropped byte", 32'd0, 32'(hostSpace));
		ackHold = 1'b0;
		waitWrites("backpressure", 8);
		for (n = 0; n < 8; n++) begin
			checkWrite("backpressure", floppyNext, {bytes[2 * n], bytes[2 * n + 1]});
			floppyNext = floppyNext + 16'd1;
		end
		// byte 17 waits for a partner
		idleCycles(20);
		checkValue("backpressure odd byte", 32'd0, 32'(wrAddrQ.size()));
		sendEnable(8'h77);
		waitWrites("backpressure ninth word", 1);
		checkWrite("backpressure ninth word", floppyNext, {bytes[16], 8'h77});
		floppyNext = floppyNext + 16'd1;
	endtask

	initial begin
		reset = 1'b1;
		hostChannel = 1'b0;
		hostData = '0;
		hostStrobe = 1'b0;
		hostEnable = 1'b0;
		ackHold = 1'b0;
		floppyNext = `IO_FLOPPY_BASE;
		acsiNext = `IO_ACSI_BASE;
		repeat (16) nextCycle();
		reset = 1'b0;
		nextCycle();
		resetState();
		floppyStrobe();
		acsiEnable();
		bothChannels();
		backPressure();
		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== ioBridge_cfg.svh ====
/*
 * widths, FIFO size and channel buffer base addresses for the I/O bridge
 */
`ifndef IO_BRIDGE_CFG_SVH
`define IO_BRIDGE_CFG_SVH

// host side byte and memory side word
`define IO_BYTE_WIDTH 8
`define IO_WORD_WIDTH 16

// 16 slots, one always kept free so at most 15 bytes stored
`define IO_FIFO_ADDR_BITS 4

// word addresses on the external memory bus
`define IO_MEM_ADDR_WIDTH 16

// first word of each channel buffer region
`define IO_FLOPPY_BASE 16'h0000
`define IO_ACSI_BASE 16'h8000

`endif

// ==== ioBridge_checker.sv ====
/*
 * concurrent checks on the external memory four-phase handshake,
 * bound into ioBridge
 */
`timescale 1ns/1ps
`default_nettype none

module ioBridge_checker (
	input wire in_clk,
	input wire reset,
	input wire memReq,
	input wire memAck,
	input wire ioPkg::memAddr_t memAddr,
	input wire ioPkg::ioWord_t memData
);

	// req may only fall once the memory answered
	reqHold: assert property (@(posedge in_clk) disable iff (reset)
		memReq && !memAck |=> memReq)
		else $error("memReq dropped before memAck");

	// address and word frozen for the whole transfer
	busStable: assert property (@(posedge in_clk) disable iff (reset)
		memReq && $past(memReq) |-> $stable(memAddr) && $stable(memData))
		else $error("memAddr or memData changed while memReq high");

	// new transfer only after the previous ack fell
	reqAfterAck: assert property (@(posedge in_clk) disable iff (reset)
		$rose(memReq) |-> !$past(memAck))
		else $error("memReq rose while memAck still high");

	// memory never acks unasked
	ackNeedsReq: assert property (@(posedge in_clk) disable iff (reset)
		$rose(memAck) |-> memReq)
		else $error("memAck rose without memReq");

endmodule

bind ioBridge ioBridge_checker handshakeCheck (
	.in_clk(in_clk),
	.reset(reset),
	.memReq(memReq),
	.memAck(memAck),
	.memAddr(memAddr),
	.memData(memData)
);

`default_nettype wire

// ==== ioFifo.sv ====
/*
 * byte FIFO for one channel, strobe and level enable write paths,
 * combinational read port with pop enable and status outputs
 */
`timescale 1ns/1ps
`default_nettype none
`include "ioBridge_cfg.svh"

module ioFifo #(
	parameter int FIFO_ADDR_BITS = `IO_FIFO_ADDR_BITS
) (
	input wire in_clk,
	input wire reset,
	input wire ioPkg::ioByte_t wrData,
	input wire wrStrobe,
	input wire wrEnable,
	input wire readEn,
	output ioPkg::ioByte_t rdData,
	output ioPkg::fifoLevel_t space,
	output logic empty,
	output logic full,
	output logic dataAvailable
);
	import ioPkg::*;

	localparam int FIFO_DEPTH = 1 << FIFO_ADDR_BITS;

	ioByte_t fifoMem [FIFO_DEPTH];
	logic [FIFO_ADDR_BITS-1:0] writePtr;
	logic [FIFO_ADDR_BITS-1:0] readPtr;
	logic [FIFO_ADDR_BITS-1:0] nextWrite;

	// host strobe is asynchronous
	logic strobeSync1;
	logic strobeSync2;
	logic strobeLast;
	logic strobeEdge;
	logic wrFire;
	logic rdFire;

	assign nextWrite = writePtr + 1'b1;

	// one slot stays unused to tell full from empty
	assign full = (readPtr == nextWrite);
	assign empty = (readPtr == writePtr);
	assign dataAvailable = !empty;
	assign space = fifoLevel_t'(readPtr - writePtr - 1'b1);

	// oldest byte, valid while dataAvailable
	assign rdData = fifoMem[readPtr];

	assign strobeEdge = strobeSync2 && !strobeLast;
	// writes into a full FIFO are lost
	assign wrFire = (strobeEdge || wrEnable) && !full;
	assign rdFire = readEn && dataAvailable;

	always_ff @(posedge in_clk) begin
		if (reset) begin
			strobeSync1 <= 1'b0;
			strobeSync2 <= 1'b0;
			strobeLast <= 1'b0;
			writePtr <= '0;
			readPtr <= '0;
		end else begin
			// two flops into in_clk, third one remembers last level
			strobeSync1 <= wrStrobe;
			strobeSync2 <= strobeSync1;
			strobeLast <= strobeSync2;
			if (wrFire)
				writePtr <= nextWrite;
			if (rdFire)
				readPtr <= readPtr + 1'b1;
		end
	end

	// storage array
	always_ff @(posedge in_clk) begin
		if (wrFire)
			fifoMem[writePtr] <= wrData;
	end

endmodule

`default_nettype wire

// ==== ioPkg.sv ====
/*
 * shared vector types and FSM state enums of the I/O bridge
 */
`default_nettype none
`include "ioBridge_cfg.svh"

package ioPkg;

	// data carried between host, FIFOs and memory
	typedef logic [`IO_BYTE_WIDTH-1:0] ioByte_t;
	typedef logic [`IO_WORD_WIDTH-1:0] ioWord_t;
	typedef logic [`IO_MEM_ADDR_WIDTH-1:0] memAddr_t;

	// free slots reported back to the host
	typedef logic [`IO_FIFO_ADDR_BITS-1:0] fifoLevel_t;

	// DMA channel, pack bytes then hand the word to the bus
	typedef enum logic [1:0] {Collect, Request, Release} dmaState_e;

	// arbiter, one grant per four-phase transfer
	typedef enum logic [1:0] {Idle, Busy, Drop} arbState_e;

endpackage

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# build the I/O bridge testbench with Verilator, run it, check the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
	--top-module ioBridgeTb -f files.f -o ioBridgeSim

./obj_dir/ioBridgeSim | tee sim.log

if grep -q "^All tests passed$" sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi
